/* cpuPkg.sv */
package cpuPkg;

	// ############################################################
	// Widths and basic words
	// ############################################################

	parameter int DataWidth = 16; // Registers and ALU.
	parameter int ByteWidth = 8; // Program memory.

	typedef logic [DataWidth-1:0] wordT;
	typedef logic [ByteWidth-1:0] byteT;
	typedef logic [1:0] regIndexT; // R1..R4 as 0..3.

	// ############################################################
	// Instruction encoding
	// ############################################################

	typedef enum logic [5:0] {
		OpBra  = 6'h00,
		OpBne  = 6'h01,
		OpBeq  = 6'h02,
		OpInc  = 6'h05,
		OpDec  = 6'h06,
		OpAnd  = 6'h0C,
		OpOrr  = 6'h0D,
		OpXor  = 6'h0F,
		OpMovh = 6'h11,
		OpMovl = 6'h14,
		OpAdd  = 6'h15,
		OpSub  = 6'h17
	} opcodeE;

	typedef enum logic [1:0] {
		StepFetchLow  = 2'd0,
		StepFetchHigh = 2'd1,
		StepExecute   = 2'd2
	} stepE;

	// Register form; immediate forms reuse bits 9..8 as Rx and 7..0 as VALUE.
	typedef struct packed {
		opcodeE opcode;
		logic sBit; // Flag write enable.
		logic [2:0] destReg;
		logic [2:0] srcReg1;
		logic [2:0] srcReg2;
	} instrT;

	// ############################################################
	// Datapath control
	// ############################################################

	typedef enum logic [2:0] {AluPassB, AluAdd, AluSub, AluAnd, AluOr, AluXor, AluInc, AluDec} aluOpE;

	typedef enum logic [1:0] {WriteNone, WriteFull, WriteLow, WriteHigh} writeModeE;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flagsT;

	typedef struct packed {
		aluOpE aluOp;
		writeModeE writeMode;
		regIndexT destIndex;
		regIndexT srcAIndex;
		regIndexT srcBIndex;
		logic flagWrite;
		logic branchTake;
	} controlT;

	typedef struct packed {
		logic valid;
		regIndexT index;
		wordT value;
	} regWriteT;

endpackage

/* fetchUnit.sv */
`timescale 1ns/100ps

module fetchUnit #(
	parameter cpuPkg::wordT ResetPc = '0
) (
	input logic Clock,
	input logic arstN,
	input cpuPkg::byteT memData,
	input cpuPkg::controlT control,
	output cpuPkg::wordT memAddress,
	output cpuPkg::instrT instruction,
	output cpuPkg::stepE step
);

	cpuPkg::wordT pc;
	cpuPkg::wordT instrWord; // Assembled from two memory bytes.
	cpuPkg::wordT branchOffset;

	assign memAddress = pc;
	assign instruction = cpuPkg::instrT'(instrWord);
	assign branchOffset = {{(cpuPkg::DataWidth - cpuPkg::ByteWidth){1'b0}},
		instrWord[cpuPkg::ByteWidth-1:0]}; // VALUE, zero extended.

	// ############################################################
	// Step counter and PC
	// ############################################################

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
			step <= cpuPkg::StepFetchLow;
		end else begin
			case (step)
				cpuPkg::StepFetchLow: begin
					step <= cpuPkg::StepFetchHigh;
					pc <= pc + cpuPkg::wordT'(1); // Past the low byte.
				end
				cpuPkg::StepFetchHigh: begin
					step <= cpuPkg::StepExecute;
					pc <= pc + cpuPkg::wordT'(1); // Past the high byte.
				end
				cpuPkg::StepExecute: begin
					step <= cpuPkg::StepFetchLow;
					if (control.branchTake)
						pc <= pc + branchOffset; // PC already points past the instruction.
				end
				default: step <= cpuPkg::StepFetchLow;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (step == cpuPkg::StepFetchLow)
			instrWord[cpuPkg::ByteWidth-1:0] <= memData; // Low byte first.
		if (step == cpuPkg::StepFetchHigh)
			instrWord[cpuPkg::DataWidth-1:cpuPkg::ByteWidth] <= memData;
	end

	assert property (@(posedge Clock) disable iff (!arstN)
		step inside {cpuPkg::StepFetchLow, cpuPkg::StepFetchHigh, cpuPkg::StepExecute});

endmodule

/* controlDecoder.sv */
`timescale 1ns/100ps

module controlDecoder (
	input cpuPkg::instrT instruction,
	input cpuPkg::stepE step,
	input cpuPkg::flagsT flags,
	output cpuPkg::controlT control
);

	cpuPkg::wordT instrWord;
	cpuPkg::regIndexT rxIndex;
	logic executeStep;
	logic regForm; // Writes DSTREG from SREG1 and maybe SREG2.
	logic twoSource;

	assign instrWord = instruction;
	assign rxIndex = instrWord[9:8]; // Immediate forms.
	assign executeStep = (step == cpuPkg::StepExecute);

	// ############################################################
	// Opcode decode
	// ############################################################

	always_comb begin
		control = '0;
		control.aluOp = cpuPkg::AluPassB;
		control.writeMode = cpuPkg::WriteNone;
		regForm = 1'b0;
		twoSource = 1'b0;
		if (executeStep) begin
			control.destIndex = instruction.destReg[1:0]; // Codes 4..7 map to 0..3.
			control.srcAIndex = instruction.srcReg1[1:0];
			control.srcBIndex = instruction.srcReg2[1:0];
			case (instruction.opcode)
				cpuPkg::OpBra: control.branchTake = 1'b1;
				cpuPkg::OpBne: control.branchTake = !flags.z;
				cpuPkg::OpBeq: control.branchTake = flags.z;
				cpuPkg::OpInc: begin
					control.aluOp = cpuPkg::AluInc;
					regForm = 1'b1;
				end
				cpuPkg::OpDec: begin
					control.aluOp = cpuPkg::AluDec;
					regForm = 1'b1;
				end
				cpuPkg::OpAnd: begin
					control.aluOp = cpuPkg::AluAnd;
					regForm = 1'b1;
					twoSource = 1'b1;
				end
				cpuPkg::OpOrr: begin
					control.aluOp = cpuPkg::AluOr;
					regForm = 1'b1;
					twoSource = 1'b1;
				end
				cpuPkg::OpXor: begin
					control.aluOp = cpuPkg::AluXor;
					regForm = 1'b1;
					twoSource = 1'b1;
				end
				cpuPkg::OpAdd: begin
					control.aluOp = cpuPkg::AluAdd;
					regForm = 1'b1;
					twoSource = 1'b1;
				end
				cpuPkg::OpSub: begin
					control.aluOp = cpuPkg::AluSub;
					regForm = 1'b1;
					twoSource = 1'b1;
				end
				cpuPkg::OpMovl: begin
					control.writeMode = cpuPkg::WriteLow;
					control.destIndex = rxIndex;
					control.srcAIndex = rxIndex; // Keeps the other byte.
				end
				cpuPkg::OpMovh: begin
					control.writeMode = cpuPkg::WriteHigh;
					control.destIndex = rxIndex;
					control.srcAIndex = rxIndex;
				end
				default: ; // No operation.
			endcase
			if (regForm) begin
				control.writeMode = cpuPkg::WriteFull;
				control.flagWrite = instruction.sBit;
			end
		end
	end

	// Checked as step 2 ends, while the fetched instruction is still stable.
	assert property (@(negedge executeStep)
		regForm |-> (instruction.destReg[2] && instruction.srcReg1[2]
			&& (!twoSource || instruction.srcReg2[2])));

endmodule

/* registerFile.sv */
`timescale 1ns/100ps

module registerFile (
	input logic Clock,
	input logic arstN,
	input cpuPkg::controlT control,
	input cpuPkg::wordT result,
	output cpuPkg::wordT operandA,
	output cpuPkg::wordT operandB,
	output cpuPkg::regWriteT regWrite
);

	cpuPkg::wordT regs [0:3]; // R1..R4.
	cpuPkg::wordT writeValue;

	assign operandA = regs[control.srcAIndex];
	assign operandB = regs[control.srcBIndex];

	// Byte writes merge the ALU byte with the destination read on port A.
	always_comb begin
		case (control.writeMode)
			cpuPkg::WriteLow: writeValue = {operandA[cpuPkg::DataWidth-1:cpuPkg::ByteWidth],
				result[cpuPkg::ByteWidth-1:0]};
			cpuPkg::WriteHigh: writeValue = {result[cpuPkg::ByteWidth-1:0],
				operandA[cpuPkg::ByteWidth-1:0]};
			default: writeValue = result;
		endcase
	end

	always_comb begin
		regWrite.valid = (control.writeMode != cpuPkg::WriteNone);
		regWrite.index = control.destIndex;
		regWrite.value = writeValue;
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (regWrite.valid) begin
			regs[control.destIndex] <= writeValue; // Only in the execute step.
		end
	end

endmodule

/* arithmeticLogicUnit.sv */
`timescale 1ns/100ps

module arithmeticLogicUnit (
	input logic Clock,
	input logic arstN,
	input cpuPkg::controlT control,
	input cpuPkg::wordT operandA,
	input cpuPkg::wordT operandB,
	input cpuPkg::byteT immediate,
	output cpuPkg::wordT result,
	output cpuPkg::flagsT flags
);

	cpuPkg::wordT operandSel; // Register or immediate B side.
	cpuPkg::wordT addend;
	logic carryIn;
	logic [cpuPkg::DataWidth:0] sumExt;
	logic carry;
	cpuPkg::flagsT nextFlags;

	assign operandSel = (control.aluOp == cpuPkg::AluPassB)
		? {{(cpuPkg::DataWidth - cpuPkg::ByteWidth){1'b0}}, immediate} : operandB;

	// ############################################################
	// Shared adder for ADD, SUB, INC and DEC
	// ############################################################

	always_comb begin
		addend = '0;
		carryIn = 1'b0;
		case (control.aluOp)
			cpuPkg::AluAdd: addend = operandSel;
			cpuPkg::AluSub: begin
				addend = ~operandSel; // A plus not B plus one.
				carryIn = 1'b1;
			end
			cpuPkg::AluInc: carryIn = 1'b1;
			cpuPkg::AluDec: addend = '1; // Same as A plus not 1 plus one.
			default: ;
		endcase
	end

	assign sumExt = {1'b0, operandA} + {1'b0, addend} + {{cpuPkg::DataWidth{1'b0}}, carryIn};

	always_comb begin
		result = sumExt[cpuPkg::DataWidth-1:0];
		carry = sumExt[cpuPkg::DataWidth];
		case (control.aluOp)
			cpuPkg::AluAnd: result = operandA & operandSel;
			cpuPkg::AluOr: result = operandA | operandSel;
			cpuPkg::AluXor: result = operandA ^ operandSel;
			cpuPkg::AluPassB: result = operandSel;
			default: ;
		endcase
		if (control.aluOp inside {cpuPkg::AluAnd, cpuPkg::AluOr, cpuPkg::AluXor, cpuPkg::AluPassB})
			carry = 1'b0; // No carry out of logic.
	end

	assign nextFlags.z = (result == '0);
	assign nextFlags.c = carry;
	assign nextFlags.n = result[cpuPkg::DataWidth-1];

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN)
			flags <= '0;
		else if (control.flagWrite)
			flags <= nextFlags; // Execute edge, S bit set.
	end

endmodule

/* cpuTop.sv */
`timescale 1ns/100ps

module cpuTop #(
	parameter cpuPkg::wordT ResetPc = '0
) (
	input logic Clock,
	input logic arstN,
	input cpuPkg::byteT memData,
	output cpuPkg::wordT memAddress,
	output cpuPkg::regWriteT regWrite,
	output cpuPkg::flagsT flags
);

	cpuPkg::instrT instruction;
	cpuPkg::stepE step;
	cpuPkg::controlT control;
	cpuPkg::wordT operandA;
	cpuPkg::wordT operandB;
	cpuPkg::wordT result;

	fetchUnit #(
		.ResetPc(ResetPc)
	) i_fetchUnit (
		.Clock(Clock),
		.arstN(arstN),
		.memData(memData),
		.control(control),
		.memAddress(memAddress),
		.instruction(instruction),
		.step(step)
	);

	controlDecoder i_controlDecoder (
		.instruction(instruction),
		.step(step),
		.flags(flags),
		.control(control)
	);

	registerFile i_registerFile (
		.Clock(Clock),
		.arstN(arstN),
		.control(control),
		.result(result),
		.operandA(operandA),
		.operandB(operandB),
		.regWrite(regWrite)
	);

	arithmeticLogicUnit i_arithmeticLogicUnit (
		.Clock(Clock),
		.arstN(arstN),
		.control(control),
		.operandA(operandA),
		.operandB(operandB),
		.immediate(instruction[cpuPkg::ByteWidth-1:0]), // VALUE for MOVL and MOVH.
		.result(result),
		.flags(flags)
	);

endmodule

/* cpuTb.sv */
`timescale 1ns/100ps

module cpuTb;

	localparam cpuPkg::wordT ResetPc = 16'h0000;
	localparam int NumInstructions = 300;
	localparam int FetchTimeout = 4; // Cycles.
	localparam int RunTimeout = 200000; // Nanoseconds.

	logic Clock = 1'b0;
	logic arstN;
	cpuPkg::byteT memData;
	cpuPkg::wordT memAddress;
	cpuPkg::regWriteT regWrite;
	cpuPkg::flagsT flags;

	cpuPkg::byteT progMem [0:255];
	cpuPkg::wordT modelRegs [0:3]; // R1..R4.
	cpuPkg::flagsT modelFlags;
	cpuPkg::wordT modelPc;
	cpuPkg::regWriteT predictedWrite;
	cpuPkg::flagsT predictedFlags;
	cpuPkg::wordT predictedPc;

	cpuTop #(
		.ResetPc(ResetPc)
	) i_cpuTop (
		.Clock(Clock),
		.arstN(arstN),
		.memData(memData),
		.memAddress(memAddress),
		.regWrite(regWrite),
		.flags(flags)
	);

	always #50 Clock = ~Clock;

	always @(negedge Clock)
		memData <= progMem[memAddress[7:0]]; // Address is stable since the rising edge.

	task automatic failRun();
		$display("Something failed");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic expectEqual(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			failRun();
		end
	endtask

	// ############################################################
	// Program generation
	// ############################################################

	function automatic cpuPkg::wordT encodeRegForm(logic [5:0] op, logic sBit,
		cpuPkg::regIndexT dst, cpuPkg::regIndexT srcA, cpuPkg::regIndexT srcB);
		return {op, sBit, 1'b1, dst, 1'b1, srcA, 1'b1, srcB}; // Register codes 4..7.
	endfunction

	function automatic cpuPkg::wordT encodeImmForm(logic [5:0] op, cpuPkg::regIndexT rx,
		cpuPkg::byteT value);
		return {op, rx, value};
	endfunction

	function automatic logic [5:0] randomOpcode();
		logic [5:0] op;
		case ($urandom % 12)
			0: op = cpuPkg::OpBra;
			1: op = cpuPkg::OpBne;
			2: op = cpuPkg::OpBeq;
			3: op = cpuPkg::OpInc;
			4: op = cpuPkg::OpDec;
			5: op = cpuPkg::OpAnd;
			6: op = cpuPkg::OpOrr;
			7: op = cpuPkg::OpXor;
			8: op = cpuPkg::OpAdd;
			9: op = cpuPkg::OpSub;
			10: op = cpuPkg::OpMovl;
			default: op = cpuPkg::OpMovh;
		endcase
		return op;
	endfunction

	task automatic storeWord(input int address, input cpuPkg::wordT word);
		progMem[address] = word[7:0]; // Low byte first.
		progMem[address + 1] = word[15:8];
	endtask

	task automatic buildProgram();
		logic [5:0] op;
		for (int r = 0; r < 4; r++) begin
			storeWord(4 * r, encodeImmForm(cpuPkg::OpMovl, 2'(r), 8'($urandom)));
			storeWord(4 * r + 2, encodeImmForm(cpuPkg::OpMovh, 2'(r), 8'($urandom)));
		end
		for (int address = 16; address < 256; address += 2) begin
			op = randomOpcode();
			if (op inside {cpuPkg::OpBra, cpuPkg::OpBne, cpuPkg::OpBeq})
				storeWord(address, encodeImmForm(op, 2'b00, 8'(($urandom % 4) * 2))); // Even.
			else if (op inside {cpuPkg::OpMovl, cpuPkg::OpMovh})
				storeWord(address, encodeImmForm(op, 2'($urandom), 8'($urandom)));
			else
				storeWord(address, encodeRegForm(op, 1'($urandom), 2'($urandom),
					2'($urandom), 2'($urandom)));
		end
	endtask

	// ############################################################
	// Reference model
	// ############################################################

	task automatic predict(input cpuPkg::wordT word);
		logic [5:0] op;
		cpuPkg::regIndexT rx;
		cpuPkg::wordT a;
		cpuPkg::wordT b;
		logic [16:0] wide;
		logic aluForm;
		logic taken;
		op = word[15:10];
		rx = word[9:8];
		a = modelRegs[word[4:3]];
		b = modelRegs[word[1:0]];
		wide = '0;
		aluForm = 1'b1;
		taken = (op == cpuPkg::OpBra) || (op == cpuPkg::OpBne && !modelFlags.z)
			|| (op == cpuPkg::OpBeq && modelFlags.z);
		predictedWrite = '0;
		predictedFlags = modelFlags;
		predictedPc = modelPc + 16'd2; // Past both bytes.
		if (taken)
			predictedPc = modelPc + 16'd2 + {8'h00, word[7:0]};
		case (op)
			cpuPkg::OpInc: wide = {1'b0, a} + 17'd1;
			cpuPkg::OpDec: wide = {1'b0, a} + {1'b0, ~16'd1} + 17'd1;
			cpuPkg::OpAnd: wide = {1'b0, a & b};
			cpuPkg::OpOrr: wide = {1'b0, a | b};
			cpuPkg::OpXor: wide = {1'b0, a ^ b};
			cpuPkg::OpAdd: wide = {1'b0, a} + {1'b0, b};
			cpuPkg::OpSub: wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
			cpuPkg::OpMovl: begin
				aluForm = 1'b0;
				predictedWrite = {1'b1, rx, modelRegs[rx][15:8], word[7:0]};
			end
			cpuPkg::OpMovh: begin
				aluForm = 1'b0;
				predictedWrite = {1'b1, rx, word[7:0], modelRegs[rx][7:0]};
			end
			default: aluForm = 1'b0; // Branches write nothing.
		endcase
		if (aluForm) begin
			predictedWrite = {1'b1, word[7:6], wide[15:0]};
			if (word[9])
				predictedFlags = {wide[15:0] == 16'h0000, wide[16], wide[15]}; // Z, C, N.
		end
	endtask

	task automatic commitModel();
		if (predictedWrite.valid)
			modelRegs[predictedWrite.index] = predictedWrite.value;
		modelFlags = predictedFlags;
		modelPc = predictedPc;
	endtask

	task automatic waitForFetch(input cpuPkg::wordT address);
		int cycles;
		cycles = 0;
		while (memAddress !== address) begin
			if (cycles >= FetchTimeout) begin
				$display("Timed out waiting for the first fetch at address %h", address);
				failRun();
			end else begin
				@(negedge Clock);
				cycles++;
			end
		end
	endtask

	initial begin
		#(RunTimeout);
		$display("The run did not finish within %0d ns", RunTimeout);
		failRun();
	end

	initial begin
		cpuPkg::wordT word;
		void'($urandom(44));
		arstN = 1'b0;
		memData = '0;
		modelPc = ResetPc;
		modelFlags = '0;
		for (int r = 0; r < 4; r++)
			modelRegs[r] = '0;
		buildProgram();
		for (int i = 0; i < 3; i++) begin
			@(negedge Clock);
			expectEqual("memAddress", 32'(memAddress), 32'(ResetPc));
			expectEqual("regWrite.valid", 32'(regWrite.valid), 32'd0);
		end
		arstN = 1'b1;
		waitForFetch(ResetPc);
		for (int n = 0; n < NumInstructions; n++) begin
			word = {progMem[8'(modelPc + 16'd1)], progMem[modelPc[7:0]]};
			predict(word);
			expectEqual("memAddress", 32'(memAddress), 32'(modelPc)); // Low byte fetch.
			expectEqual("regWrite.valid", 32'(regWrite.valid), 32'd0);
			@(negedge Clock);
			expectEqual("memAddress", 32'(memAddress), 32'(modelPc + 16'd1));
			expectEqual("regWrite.valid", 32'(regWrite.valid), 32'd0);
			@(negedge Clock);
			expectEqual("memAddress", 32'(memAddress), 32'(modelPc + 16'd2));
			expectEqual("regWrite.valid", 32'(regWrite.valid), 32'(predictedWrite.valid));
			if (predictedWrite.valid) begin
				expectEqual("regWrite.index", 32'(regWrite.index), 32'(predictedWrite.index));
				expectEqual("regWrite.value", 32'(regWrite.value), 32'(predictedWrite.value));
			end
			expectEqual("flags", 32'(flags), 32'(modelFlags));
			commitModel(); // DUT commits at the coming rising edge.
			@(negedge Clock);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

/* filelist.f */
cpuPkg.sv
fetchUnit.sv
controlDecoder.sv
registerFile.sv
arithmeticLogicUnit.sv
cpuTop.sv
cpuTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f filelist.f --top-module cpuTb \
	--Mdir obj_dir -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "Everything OK" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
